// File: verilog.f
+incdir+hw
+incdir+verification
hw/shifterPkg.sv
hw/shiftStage.sv
hw/barrelShifter.sv
hw/shiftRegs.sv
hw/shifterTop.sv
verification/shifterTb.sv

// File: Bender.yml
package:
  name: barrel_shifter

sources:
  - include_dirs:
      - hw
    files:
      - hw/shifterPkg.sv
      - hw/shiftStage.sv
      - hw/barrelShifter.sv
      - hw/shiftRegs.sv
      - hw/shifterTop.sv
  - target: test
    include_dirs:
      - hw
      - verification
    files:
      - verification/shifterTb.sv

// File: verification/shifterTbTasks.svh
// AXI4-Lite host tasks for the shifter testbench
// Single beat write and read with optional back-pressure, plus done polling

// One clock, then settle past the edge before touching inputs
task automatic nextCycle();
  @(posedge clk);
  #1;
endtask

// Random hold with the ready low, none when back-pressure is off
task automatic holdOff();
  int n;
  n = 0;
  if (stallMax > 0) begin
    n = $unsigned($random(seed)) % (stallMax + 1);
  end
  repeat (n) begin
    nextCycle();
  end
endtask

task automatic writeReg(input logic [3:0] addr, input logic [31:0] data,
                        output logic [1:0] resp);
  int cycles;
  axiReq.awValid = 1'b1;
  axiReq.awAddr  = addr;
  axiReq.wValid  = 1'b1;
  axiReq.wData   = data;
  cycles = 0;
  // Ready seen now means the handshake lands on the next edge
  while (!axiRsp.awReady) begin
    nextCycle();
    cycles++;
    if (cycles > WaitLimit) timeoutAbort("write address and data never accepted");
  end
  nextCycle();
  axiReq.awValid = 1'b0;
  axiReq.wValid  = 1'b0;
  holdOff();
  axiReq.bReady = 1'b1;
  cycles = 0;
  while (!axiRsp.bValid) begin
    nextCycle();
    cycles++;
    if (cycles > WaitLimit) timeoutAbort("write response never arrived");
  end
  resp = axiRsp.bResp;
  nextCycle();
  axiReq.bReady = 1'b0;
endtask

task automatic readReg(input logic [3:0] addr, output logic [31:0] data,
                       output logic [1:0] resp);
  int cycles;
  axiReq.arValid = 1'b1;
  axiReq.arAddr  = addr;
  cycles = 0;
  while (!axiRsp.arReady) begin
    nextCycle();
    cycles++;
    if (cycles > WaitLimit) timeoutAbort("read address never accepted");
  end
  nextCycle();
  axiReq.arValid = 1'b0;
  holdOff();
  axiReq.rReady = 1'b1;
  cycles = 0;
  while (!axiRsp.rValid) begin
    nextCycle();
    cycles++;
    if (cycles > WaitLimit) timeoutAbort("read data never arrived");
  end
  data = axiRsp.rData;
  resp = axiRsp.rResp;
  nextCycle();
  axiReq.rReady = 1'b0;
endtask

// Poll STATUS until the done bit shows up
task automatic waitDone(output logic [31:0] status);
  logic [1:0] resp;
  int polls;
  polls  = 0;
  status = '0;
  while (!status[1]) begin
    readReg(`REG_STATUS, status, resp);
    polls++;
    if (polls > WaitLimit) timeoutAbort("done flag never set in STATUS");
  end
endtask

// File: verification/shifterTb.sv
// Barrel shifter testbench
// Drives the AXI4-Lite slave with random and directed ops against a bitwise model
`timescale 1ns/10ps
`default_nettype none

`include "shifter_macros.svh"

module shifterTb;

  import shifterPkg::*;

  localparam int WaitLimit = 1000;

  logic   clk;
  logic   rstN;
  axiReqT axiReq;
  axiRspT axiRsp;

  integer      seed;
  int          stallMax;
  int          checkCount;
  int          errorCount;
  int          testErrors;
  int          i;
  int          op;
  int          amts [5] = '{0, 1, 4, 16, 31};
  logic [31:0] operand;
  logic [31:0] res;
  logic [31:0] rdVal;
  logic [31:0] status;
  logic [1:0]  resp;
  logic [4:0]  amtA;
  logic [4:0]  amtB;

  shifterTop uut (
    .clk    (clk),
    .rstN   (rstN),
    .axiReq (axiReq),
    .axiRsp (axiRsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic timeoutAbort(input string what);
    $display("Timeout after %0d cycles at %0t: %s", WaitLimit, $time, what);
    $display(">>> FAIL");
    $finish;
  endtask

  `include "shifterTbTasks.svh"

  // One move per loop pass, amount times over
  function automatic logic [31:0] modelShift(input logic [31:0] val, input int opSel,
                                             input int amt);
    logic [31:0] w;
    int k;
    w = val;
    for (k = 0; k < amt; k++) begin
      case (opSel)
        0:       w = {w[30:0], w[31]};
        1:       w = {w[30:0], 1'b0};
        2:       w = {w[0], w[31:1]};
        default: w = {1'b0, w[31:1]};
      endcase
    end
    return w;
  endfunction

  // CTRL layout, op in 9:8 and amount in 4:0
  function automatic logic [31:0] ctrlFor(input int opSel, input int amt);
    return {22'd0, opSel[1:0], 3'd0, amt[4:0]};
  endfunction

  task automatic checkEq(input string name, input logic [31:0] expVal,
                         input logic [31:0] actVal);
    checkCount++;
    assert (actVal === expVal) else begin
      $display("Error: time %0t %s expected %h actual %h", $time, name, expVal, actVal);
      errorCount++;
    end
  endtask

  // Full host sequence for one op, result checked against the model
  task automatic runOp(input logic [31:0] val, input int opSel, input int amt,
                       output logic [31:0] result);
    logic [1:0]  r;
    logic [31:0] st;
    writeReg(`REG_OPERAND, val, r);
    checkEq("bResp", 32'd0, {30'd0, r});
    writeReg(`REG_CTRL, ctrlFor(opSel, amt), r);
    checkEq("bResp", 32'd0, {30'd0, r});
    // Without stalls the first read lands while the item is still in the pipeline
    if (stallMax == 0) begin
      readReg(`REG_STATUS, st, r);
      checkEq("STATUS while busy", 32'd1, st);
    end
    waitDone(st);
    checkEq("STATUS", 32'd2, st);
    readReg(`REG_RESULT, result, r);
    checkEq("rResp", 32'd0, {30'd0, r});
    checkEq("RESULT", modelShift(val, opSel, amt), result);
  endtask

  task automatic endTest(input int num, input string name);
    $display("Test %0d %s finished with %0d errors", num, name, errorCount - testErrors);
    testErrors = errorCount;
  endtask

  initial begin
    axiReq     = '0;
    rstN       = 1'b0;
    seed       = 19;
    stallMax   = 0;
    checkCount = 0;
    errorCount = 0;
    testErrors = 0;
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;
    nextCycle();

    // Everything reads back zero out of reset
    readReg(`REG_OPERAND, rdVal, resp);
    checkEq("OPERAND", 32'd0, rdVal);
    checkEq("rResp", 32'd0, {30'd0, resp});
    readReg(`REG_CTRL, rdVal, resp);
    checkEq("CTRL", 32'd0, rdVal);
    checkEq("rResp", 32'd0, {30'd0, resp});
    readReg(`REG_RESULT, rdVal, resp);
    checkEq("RESULT", 32'd0, rdVal);
    checkEq("rResp", 32'd0, {30'd0, resp});
    readReg(`REG_STATUS, rdVal, resp);
    checkEq("STATUS", 32'd0, rdVal);
    checkEq("rResp", 32'd0, {30'd0, resp});
    endTest(1, "reset values");

    for (i = 0; i < 200; i++) begin
      operand = $random(seed);
      op      = $unsigned($random(seed)) % 4;
      runOp(operand, op, $unsigned($random(seed)) % 32, res);
    end
    endTest(2, "random ops");

    // Edge amounts, then rotate right 32-k against rotate left k
    operand = $random(seed);
    for (op = 0; op < 4; op++) begin
      for (i = 0; i < 5; i++) begin
        runOp(operand, op, amts[i], res);
        if (amts[i] == 0) checkEq("RESULT for amount 0", operand, res);
      end
    end
    for (i = 1; i < 5; i++) begin
      runOp(operand, 2, 32 - amts[i], res);
      checkEq("RESULT rotate right vs left", modelShift(operand, 0, amts[i]), res);
    end
    endTest(3, "edge amounts");

    // Second CTRL write must win
    operand = $random(seed);
    op      = $unsigned($random(seed)) % 4;
    amtA    = 5'd3;
    amtB    = 5'd19;
    writeReg(`REG_OPERAND, operand, resp);
    writeReg(`REG_CTRL, ctrlFor(op, amtA), resp);
    writeReg(`REG_CTRL, ctrlFor(op, amtB), resp);
    waitDone(status);
    readReg(`REG_RESULT, res, resp);
    checkEq("RESULT after two CTRL writes", modelShift(operand, op, amtB), res);
    endTest(4, "back to back ctrl");

    // Unmapped offsets fail and leave the registers alone
    operand = $random(seed);
    runOp(operand, 1, 7, res);
    writeReg(4'h2, $random(seed), resp);
    checkEq("bResp unmapped", 32'd2, {30'd0, resp});
    writeReg(4'hE, $random(seed), resp);
    checkEq("bResp unmapped", 32'd2, {30'd0, resp});
    readReg(4'h2, rdVal, resp);
    checkEq("rData unmapped", 32'd0, rdVal);
    checkEq("rResp unmapped", 32'd2, {30'd0, resp});
    readReg(4'hE, rdVal, resp);
    checkEq("rData unmapped", 32'd0, rdVal);
    checkEq("rResp unmapped", 32'd2, {30'd0, resp});
    readReg(`REG_OPERAND, rdVal, resp);
    checkEq("OPERAND", operand, rdVal);
    readReg(`REG_CTRL, rdVal, resp);
    checkEq("CTRL", ctrlFor(1, 7), rdVal);
    readReg(`REG_RESULT, rdVal, resp);
    checkEq("RESULT", modelShift(operand, 1, 7), rdVal);
    endTest(5, "unmapped offsets");

    // Slow host on B and R
    stallMax = 7;
    for (i = 0; i < 20; i++) begin
      operand = $random(seed);
      op      = $unsigned($random(seed)) % 4;
      runOp(operand, op, $unsigned($random(seed)) % 32, res);
      readReg(`REG_OPERAND, rdVal, resp);
      checkEq("OPERAND", operand, rdVal);
    end
    stallMax = 0;
    endTest(6, "response back-pressure");

    $display("Tests 6, checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/shifterTop.sv
// Memory mapped barrel shifter
// AXI4-Lite register slave in front of the two stage shifter pipeline
`timescale 1ns/10ps
`default_nettype none

`include "shifter_macros.svh"

module shifterTop (
  input  logic               clk,
  input  logic               rstN,
  input  shifterPkg::axiReqT axiReq,
  output shifterPkg::axiRspT axiRsp
);

  import shifterPkg::*;

  // Core side of the register block
  shiftReqT                req;
  logic                    reqValid;
  logic [`SHIFT_WIDTH-1:0] rspData;
  logic                    rspValid;

  // Bus decode and register file
  shiftRegs regs (
    .clk      (clk),
    .rstN     (rstN),
    .axiReq   (axiReq),
    .axiRsp   (axiRsp),
    .req      (req),
    .reqValid (reqValid),
    .rspData  (rspData),
    .rspValid (rspValid)
  );

  // Always ready, fixed latency of two
  barrelShifter shifter (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .reqValid (reqValid),
    .rspData  (rspData),
    .rspValid (rspValid)
  );

endmodule

`default_nettype wire

// File: hw/shiftRegs.sv
// AXI4-Lite register slave for the shifter
// Holds OPERAND, CTRL, RESULT and STATUS, launches requests, captures results
`timescale 1ns/10ps
`default_nettype none

`include "shifter_macros.svh"

module shiftRegs (
  input  logic                    clk,
  input  logic                    rstN,
  input  shifterPkg::axiReqT      axiReq,
  output shifterPkg::axiRspT      axiRsp,
  output shifterPkg::shiftReqT    req,
  output logic                    reqValid,
  input  logic [`SHIFT_WIDTH-1:0] rspData,
  input  logic                    rspValid
);

  import shifterPkg::*;

  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  // Channel state
  logic                    awReadyQ;
  logic                    bValidQ;
  logic [1:0]              bRespQ;
  logic                    arReadyQ;
  logic                    rValidQ;
  logic [`SHIFT_WIDTH-1:0] rDataQ;
  logic [1:0]              rRespQ;

  // Register file
  logic [`SHIFT_WIDTH-1:0]    operandQ;
  shiftOpE                    ctrlOp;
  logic [`SHIFT_AMT_BITS-1:0] ctrlAmt;
  logic [`SHIFT_WIDTH-1:0]    resultQ;
  logic                       doneQ;
  logic [1:0]                 inFlightQ;
  logic [1:0]                 nextInFlight;

  // Decode
  logic                    wrFire;
  logic                    wrOperand;
  logic                    wrCtrl;
  logic                    rdFire;
  logic                    busy;
  logic [`SHIFT_WIDTH-1:0] ctrlWord;
  logic [`SHIFT_WIDTH-1:0] statusWord;
  logic [`SHIFT_WIDTH-1:0] rdData;
  logic [1:0]              rdResp;

  // Handshakes complete in the cycle the ready pulse is up
  assign wrFire    = awReadyQ && axiReq.awValid && axiReq.wValid;
  assign wrOperand = wrFire && (axiReq.awAddr == `REG_OPERAND);
  assign wrCtrl    = wrFire && (axiReq.awAddr == `REG_CTRL);
  assign rdFire    = arReadyQ && axiReq.arValid;

  // Op in 9:8, amount in 4:0
  assign ctrlWord = {{(`SHIFT_WIDTH - 10){1'b0}}, ctrlOp, 3'b000, ctrlAmt};

  // A launch still sitting in reqValid counts as busy
  assign busy       = (inFlightQ != 2'd0) || reqValid;
  assign statusWord = {{(`SHIFT_WIDTH - 2){1'b0}}, doneQ, busy};

  // Launch adds one, capture removes one
  assign nextInFlight = inFlightQ + {1'b0, reqValid} - {1'b0, rspValid};

  // Read mux, sampled on the AR handshake
  always_comb begin
    rdData = '0;
    rdResp = RespOkay;
    case (axiReq.arAddr)
      `REG_OPERAND: rdData = operandQ;
      `REG_CTRL:    rdData = ctrlWord;
      `REG_RESULT:  rdData = resultQ;
      `REG_STATUS:  rdData = statusWord;
      default:      rdResp = RespSlvErr;
    endcase
  end

  // Write channel, AW and W accepted together
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      awReadyQ <= 1'b0;
      bValidQ  <= 1'b0;
      bRespQ   <= RespOkay;
    end else begin
      // One cycle pulse, blocked while a response waits
      awReadyQ <= axiReq.awValid && axiReq.wValid && !bValidQ && !awReadyQ;
      if (wrFire) begin
        bValidQ <= 1'b1;
        bRespQ  <= (wrOperand || wrCtrl) ? RespOkay : RespSlvErr;
      end else if (bValidQ && axiReq.bReady) begin
        bValidQ <= 1'b0;
      end
    end
  end

  // Read channel
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      arReadyQ <= 1'b0;
      rValidQ  <= 1'b0;
      rDataQ   <= '0;
      rRespQ   <= RespOkay;
    end else begin
      arReadyQ <= axiReq.arValid && !rValidQ && !arReadyQ;
      if (rdFire) begin
        rValidQ <= 1'b1;
        rDataQ  <= rdData;
        rRespQ  <= rdResp;
      end else if (rValidQ && axiReq.rReady) begin
        rValidQ <= 1'b0;
      end
    end
  end

  // Registers and launch pulse
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      operandQ  <= '0;
      ctrlOp    <= opRotL;
      ctrlAmt   <= '0;
      resultQ   <= '0;
      doneQ     <= 1'b0;
      inFlightQ <= 2'd0;
      reqValid  <= 1'b0;
    end else begin
      if (wrOperand) begin
        operandQ <= axiReq.wData;
      end
      if (wrCtrl) begin
        ctrlOp  <= shiftOpE'(axiReq.wData[9:8]);
        ctrlAmt <= axiReq.wData[`SHIFT_AMT_BITS-1:0];
      end
      // Request goes out the cycle after the CTRL handshake
      reqValid  <= wrCtrl;
      inFlightQ <= nextInFlight;
      // Latest completion always wins
      if (rspValid) begin
        resultQ <= rspData;
      end
      // Done on capture, a new launch clears it
      if (wrCtrl) begin
        doneQ <= 1'b0;
      end else if (rspValid) begin
        doneQ <= 1'b1;
      end
    end
  end

  // Request fields straight from the registers
  always_comb begin
    req.operand = operandQ;
    req.amount  = ctrlAmt;
    req.op      = ctrlOp;
  end

  // Slave side of the bus
  always_comb begin
    axiRsp.awReady = awReadyQ;
    axiRsp.wReady  = awReadyQ;
    axiRsp.bValid  = bValidQ;
    axiRsp.bResp   = bRespQ;
    axiRsp.arReady = arReadyQ;
    axiRsp.rValid  = rValidQ;
    axiRsp.rData   = rDataQ;
    axiRsp.rResp   = rRespQ;
  end

endmodule

`default_nettype wire

// File: hw/barrelShifter.sv
// Logarithmic barrel shifter
// Stages 16 and 8, register, stages 4, 2 and 1, register; latency of two cycles
`timescale 1ns/10ps
`default_nettype none

`include "shifter_macros.svh"

module barrelShifter (
  input  logic                    clk,
  input  logic                    rstN,
  input  shifterPkg::shiftReqT    req,
  input  logic                    reqValid,
  output logic [`SHIFT_WIDTH-1:0] rspData,
  output logic                    rspValid
);

  import shifterPkg::*;

  // First half outputs
  logic [`SHIFT_WIDTH-1:0] s16Out;
  logic [`SHIFT_WIDTH-1:0] s8Out;

  // Mid pipeline register
  logic [`SHIFT_WIDTH-1:0] midData;
  shiftOpE                 midOp;
  logic [2:0]              midAmt;
  logic                    midValid;

  // Second half outputs
  logic [`SHIFT_WIDTH-1:0] s4Out;
  logic [`SHIFT_WIDTH-1:0] s2Out;
  logic [`SHIFT_WIDTH-1:0] s1Out;

  // Amount bits 4 and 3
  shiftStage #(.Dist(16)) stage16 (
    .in  (req.operand),
    .op  (req.op),
    .sel (req.amount[4]),
    .out (s16Out)
  );

  shiftStage #(.Dist(8)) stage8 (
    .in  (s16Out),
    .op  (req.op),
    .sel (req.amount[3]),
    .out (s8Out)
  );

  // Amount bits 2 to 0, taken from the mid register
  shiftStage #(.Dist(4)) stage4 (
    .in  (midData),
    .op  (midOp),
    .sel (midAmt[2]),
    .out (s4Out)
  );

  shiftStage #(.Dist(2)) stage2 (
    .in  (s4Out),
    .op  (midOp),
    .sel (midAmt[1]),
    .out (s2Out)
  );

  shiftStage #(.Dist(1)) stage1 (
    .in  (s2Out),
    .op  (midOp),
    .sel (midAmt[0]),
    .out (s1Out)
  );

  // Valid bits, one item per register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      midValid <= 1'b0;
      rspValid <= 1'b0;
    end else begin
      midValid <= reqValid;
      rspValid <= midValid;
    end
  end

  // Data only loads alongside its valid
  always_ff @(posedge clk) begin
    if (reqValid) begin
      midData <= s8Out;
      midOp   <= req.op;
      midAmt  <= req.amount[2:0];
    end
    if (midValid) begin
      rspData <= s1Out;
    end
  end

endmodule

`default_nettype wire

// File: hw/shiftStage.sv
// Fixed distance shifter stage
// Moves the word Dist places by the op rule when sel is set
`timescale 1ns/10ps
`default_nettype none

`include "shifter_macros.svh"

module shiftStage #(
  parameter int Dist = 4
) (
  input  logic [`SHIFT_WIDTH-1:0] in,
  input  shifterPkg::shiftOpE     op,
  input  logic                    sel,
  output logic [`SHIFT_WIDTH-1:0] out
);

  import shifterPkg::*;

  // Word after the move, before the select mux
  logic [`SHIFT_WIDTH-1:0] moved;

  always_comb begin
    case (op)
      // Top Dist bits wrap into the bottom
      opRotL: begin
        moved = {in[`SHIFT_WIDTH-Dist-1:0], in[`SHIFT_WIDTH-1:`SHIFT_WIDTH-Dist]};
      end
      // Zeros come in from the bottom
      opShiftL: begin
        moved = {in[`SHIFT_WIDTH-Dist-1:0], {Dist{1'b0}}};
      end
      // Bottom Dist bits wrap into the top
      opRotR: begin
        moved = {in[Dist-1:0], in[`SHIFT_WIDTH-1:Dist]};
      end
      // Logical right, zero fill at the top
      default: begin
        moved = {{Dist{1'b0}}, in[`SHIFT_WIDTH-1:Dist]};
      end
    endcase
  end

  // Unselected stage passes the word through
  assign out = sel ? moved : in;

endmodule

`default_nettype wire

// File: hw/shifterPkg.sv
// Shifter package
// Op encoding, shift request and AXI4-Lite channel bundles
`default_nettype none

`include "shifter_macros.svh"

package shifterPkg;

  // Op encoding, same values as the CTRL op field
  typedef enum logic [1:0] {
    opRotL   = 2'b00,
    opShiftL = 2'b01,
    opRotR   = 2'b10,
    opShiftR = 2'b11
  } shiftOpE;

  // One request into the barrel shifter
  typedef struct packed {
    logic [`SHIFT_WIDTH-1:0]    operand;
    logic [`SHIFT_AMT_BITS-1:0] amount;
    shiftOpE                    op;
  } shiftReqT;

  // Master driven AXI4-Lite fields
  typedef struct packed {
    logic                      awValid;
    logic [`AXI_ADDR_BITS-1:0] awAddr;
    logic                      wValid;
    logic [`SHIFT_WIDTH-1:0]   wData;
    logic                      bReady;
    logic                      arValid;
    logic [`AXI_ADDR_BITS-1:0] arAddr;
    logic                      rReady;
  } axiReqT;

  // Slave driven AXI4-Lite fields
  typedef struct packed {
    logic                    awReady;
    logic                    wReady;
    logic                    bValid;
    logic [1:0]              bResp;
    logic                    arReady;
    logic                    rValid;
    logic [`SHIFT_WIDTH-1:0] rData;
    logic [1:0]              rResp;
  } axiRspT;

endpackage

`default_nettype wire

// File: hw/shifter_macros.svh
// Barrel shifter constants
// Word and amount widths, AXI address width and the register map
`ifndef SHIFTER_MACROS_SVH
`define SHIFTER_MACROS_SVH

// Data path
`define SHIFT_WIDTH     32
// Enough bits for amounts 0 to 31
`define SHIFT_AMT_BITS  5

// AXI4-Lite address, four word registers
`define AXI_ADDR_BITS   4

// Register offsets
`define REG_OPERAND     4'h0
`define REG_CTRL        4'h4
// Read only
`define REG_RESULT      4'h8
`define REG_STATUS      4'hC

`endif
